// File: common/pkt_chk_consts.svh
// packet checker constants

`ifndef PKT_CHK_CONSTS_SVH
`define PKT_CHK_CONSTS_SVH

// link beat width in bytes
`define PKT_CHK_DATA_BYTES 8

// largest packet, 8 beats of 8 bytes
`define PKT_CHK_MTU_BYTES 64

// expected-packet table depth
`define PKT_CHK_NUM_PKTS 4

// byte length must hold the value 64
`define PKT_CHK_BLEN_W 7

// table entry index width
`define PKT_CHK_IDX_W 2

// beat slot pointer inside the packet buffer
`define PKT_CHK_WPTR_W 3

`endif

// File: common/pkt_chk_pkg.sv
// packet checker types

`default_nettype none

`include "pkt_chk_consts.svh"

package pkt_chk_pkg;

    // one observed AXI-Stream cycle
    typedef struct packed {
        logic                              tvalid;
        logic                              tready;
        logic [`PKT_CHK_DATA_BYTES*8-1:0]  tdata;
        logic [`PKT_CHK_DATA_BYTES-1:0]    tkeep;
        logic                              tlast;
    } axis_beat_t;

    // assembled packet, done is a one-cycle strobe
    typedef struct packed {
        logic                              done;
        logic                              oversize;
        logic [`PKT_CHK_BLEN_W-1:0]        blen;
        logic [`PKT_CHK_MTU_BYTES*8-1:0]   data;
    } pkt_t;

    // table load port
    // word goes to slot word_idx of entry idx, blen only when set_blen is high
    typedef struct packed {
        logic                              wr;
        logic                              clear;
        logic [`PKT_CHK_IDX_W-1:0]         idx;
        logic [`PKT_CHK_WPTR_W-1:0]        word_idx;
        logic [`PKT_CHK_DATA_BYTES*8-1:0]  word;
        logic                              set_blen;
        logic [`PKT_CHK_BLEN_W-1:0]        blen;
    } tbl_wr_t;

    typedef enum logic [1:0] {
        CHK_MATCH    = 2'd0,
        CHK_DUP      = 2'd1,
        CHK_MISS     = 2'd2,
        CHK_OVERSIZE = 2'd3
    } chk_kind_e;

    // per-packet verdict
    // idx is only meaningful for match and dup
    typedef struct packed {
        logic                              valid;
        chk_kind_e                         kind;
        logic [`PKT_CHK_IDX_W-1:0]         idx;
        logic [`PKT_CHK_BLEN_W-1:0]        blen;
    } chk_result_t;

endpackage

`default_nettype wire

// File: design/axis_pkt_chk.sv
// AXI-Stream packet checker top

`timescale 1ns/1ps
`default_nettype none

`include "pkt_chk_consts.svh"

module axis_pkt_chk (
    input  wire logic                          axis_in,
    input  wire logic                          rst_n,
    input  pkt_chk_pkg::axis_beat_t            beat,
    input  pkt_chk_pkg::tbl_wr_t               tbl_wr,
    output pkt_chk_pkg::chk_result_t           result,
    output logic [`PKT_CHK_NUM_PKTS-1:0]       rcvd,
    output logic [15:0]                        miss_count
);

    pkt_chk_pkg::pkt_t pkt;

    logic [`PKT_CHK_NUM_PKTS-1:0][`PKT_CHK_MTU_BYTES*8-1:0] exp_data;
    logic [`PKT_CHK_NUM_PKTS-1:0][`PKT_CHK_BLEN_W-1:0]      exp_blen;
    logic                                                   mark;
    logic [`PKT_CHK_IDX_W-1:0]                              mark_idx;

    // builds packets from the observed beats
    pkt_assembler u_pkt_assembler (
        .axis_in (axis_in),
        .rst_n   (rst_n),
        .beat    (beat),
        .pkt     (pkt)
    );

    // loadable expected packets and received flags
    expect_table u_expect_table (
        .axis_in  (axis_in),
        .rst_n    (rst_n),
        .tbl_wr   (tbl_wr),
        .mark     (mark),
        .mark_idx (mark_idx),
        .exp_data (exp_data),
        .exp_blen (exp_blen),
        .rcvd     (rcvd)
    );

    pkt_matcher u_pkt_matcher (
        .axis_in    (axis_in),
        .rst_n      (rst_n),
        .pkt        (pkt),
        .exp_data   (exp_data),
        .exp_blen   (exp_blen),
        .rcvd       (rcvd),
        .mark       (mark),
        .mark_idx   (mark_idx),
        .result     (result),
        .miss_count (miss_count)
    );

endmodule

`default_nettype wire

// File: design/pkt_matcher.sv
// packet matcher

`timescale 1ns/1ps
`default_nettype none

`include "pkt_chk_consts.svh"

module pkt_matcher (
    input  wire logic                                              axis_in,
    input  wire logic                                              rst_n,
    input  pkt_chk_pkg::pkt_t                                      pkt,
    input  wire logic [`PKT_CHK_NUM_PKTS-1:0][`PKT_CHK_MTU_BYTES*8-1:0] exp_data,
    input  wire logic [`PKT_CHK_NUM_PKTS-1:0][`PKT_CHK_BLEN_W-1:0]      exp_blen,
    input  wire logic [`PKT_CHK_NUM_PKTS-1:0]                      rcvd,
    output logic                                                   mark,
    output logic [`PKT_CHK_IDX_W-1:0]                              mark_idx,
    output pkt_chk_pkg::chk_result_t                               result,
    output logic [15:0]                                            miss_count
);

    localparam int NUM_PKTS  = `PKT_CHK_NUM_PKTS;
    localparam int MTU_BYTES = `PKT_CHK_MTU_BYTES;
    localparam int BLEN_W    = `PKT_CHK_BLEN_W;
    localparam int IDX_W     = `PKT_CHK_IDX_W;

    logic [NUM_PKTS-1:0] eq;
    logic [NUM_PKTS-1:0] rcvd_eff;
    logic [NUM_PKTS-1:0] avail;
    logic [NUM_PKTS-1:0] dup;
    logic                match_hit;
    logic [IDX_W-1:0]    match_idx;
    logic [IDX_W-1:0]    dup_idx;

    // equal when lengths agree and every byte below the length agrees
    for (genvar e = 0; e < NUM_PKTS; e++) begin : g_entry
        logic [MTU_BYTES-1:0] byte_ok;
        for (genvar b = 0; b < MTU_BYTES; b++) begin : g_byte
            assign byte_ok[b] = (BLEN_W'(b) >= pkt.blen) ||
                                (exp_data[e][b*8 +: 8] == pkt.data[b*8 +: 8]);
        end
        assign eq[e] = (exp_blen[e] == pkt.blen) && (&byte_ok);
    end

    // a mark still in flight counts as received, so a back-to-back copy is a dup
    always_comb begin
        rcvd_eff = rcvd;
        if (mark) begin
            rcvd_eff[mark_idx] = 1'b1;
        end
    end

    assign avail = eq & ~rcvd_eff;
    assign dup   = eq & rcvd_eff;

    // lowest index wins
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        dup_idx   = '0;
        for (int i = NUM_PKTS - 1; i >= 0; i--) begin
            if (avail[i]) begin
                match_hit = 1'b1;
                match_idx = IDX_W'(i);
            end
            if (dup[i]) begin
                dup_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge axis_in or negedge rst_n) begin
        if (!rst_n) begin
            result     <= '0;
            mark       <= 1'b0;
            mark_idx   <= '0;
            miss_count <= '0;
        end else begin
            result.valid <= pkt.done;
            mark         <= 1'b0;
            if (pkt.done) begin
                result.blen <= pkt.blen;
                result.idx  <= '0;
                if (pkt.oversize) begin
                    result.kind <= pkt_chk_pkg::CHK_OVERSIZE;
                end else if (match_hit) begin
                    result.kind <= pkt_chk_pkg::CHK_MATCH;
                    result.idx  <= match_idx;
                    mark        <= 1'b1;
                    mark_idx    <= match_idx;
                end else if (|dup) begin
                    result.kind <= pkt_chk_pkg::CHK_DUP;
                    result.idx  <= dup_idx;
                end else begin
                    result.kind <= pkt_chk_pkg::CHK_MISS;
                end
                // misses and oversize packets both count, saturating
                if ((pkt.oversize || (!match_hit && !(|dup))) && !(&miss_count)) begin
                    miss_count <= miss_count + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: expect_table/expect_table.sv
// expected packet table

`timescale 1ns/1ps
`default_nettype none

`include "pkt_chk_consts.svh"

module expect_table (
    input  wire logic                                          axis_in,
    input  wire logic                                          rst_n,
    input  pkt_chk_pkg::tbl_wr_t                               tbl_wr,
    input  wire logic                                          mark,
    input  wire logic [`PKT_CHK_IDX_W-1:0]                     mark_idx,
    output logic [`PKT_CHK_NUM_PKTS-1:0][`PKT_CHK_MTU_BYTES*8-1:0] exp_data,
    output logic [`PKT_CHK_NUM_PKTS-1:0][`PKT_CHK_BLEN_W-1:0]      exp_blen,
    output logic [`PKT_CHK_NUM_PKTS-1:0]                       rcvd
);

    localparam int NUM_PKTS = `PKT_CHK_NUM_PKTS;
    localparam int WORD_W   = `PKT_CHK_DATA_BYTES * 8;
    localparam int MTU_W    = `PKT_CHK_MTU_BYTES * 8;
    localparam int BLEN_W   = `PKT_CHK_BLEN_W;

    logic [NUM_PKTS-1:0][MTU_W-1:0]  data_mem;
    logic [NUM_PKTS-1:0][BLEN_W-1:0] blen_mem;
    logic [NUM_PKTS-1:0]             rcvd_q;
    logic [NUM_PKTS-1:0]             mark_vec;

    // packet words, loaded one beat slot at a time
    always_ff @(posedge axis_in) begin
        if (tbl_wr.wr) begin
            data_mem[tbl_wr.idx][tbl_wr.word_idx*WORD_W +: WORD_W] <= tbl_wr.word;
            if (tbl_wr.set_blen) begin
                blen_mem[tbl_wr.idx] <= tbl_wr.blen;
            end
        end
    end

    // one-hot of the entry the matcher has just claimed
    always_comb begin
        mark_vec = '0;
        if (mark) begin
            mark_vec[mark_idx] = 1'b1;
        end
    end

    // received flags
    // clear has priority over a mark in the same cycle
    always_ff @(posedge axis_in or negedge rst_n) begin
        if (!rst_n) begin
            rcvd_q <= '0;
        end else if (tbl_wr.clear) begin
            rcvd_q <= '0;
        end else begin
            rcvd_q <= rcvd_q | mark_vec;
        end
    end

    assign exp_data = data_mem;
    assign exp_blen = blen_mem;
    assign rcvd     = rcvd_q;

endmodule

`default_nettype wire

// File: pkt_assembler/pkt_assembler.sv
// packet assembler

`timescale 1ns/1ps
`default_nettype none

`include "pkt_chk_consts.svh"

module pkt_assembler (
    input  wire logic               axis_in,
    input  wire logic               rst_n,
    input  pkt_chk_pkg::axis_beat_t beat,
    output pkt_chk_pkg::pkt_t       pkt
);

    localparam int DATA_BYTES = `PKT_CHK_DATA_BYTES;
    localparam int WORD_W     = DATA_BYTES * 8;
    localparam int MTU_W      = `PKT_CHK_MTU_BYTES * 8;
    localparam int NUM_BEATS  = `PKT_CHK_MTU_BYTES / DATA_BYTES;
    localparam int BLEN_W     = `PKT_CHK_BLEN_W;
    localparam int WPTR_W     = `PKT_CHK_WPTR_W;

    localparam logic [WPTR_W-1:0] LAST_SLOT = WPTR_W'(NUM_BEATS - 1);

    // number of valid bytes in a beat
    function automatic logic [BLEN_W-1:0] keep_bytes(input logic [DATA_BYTES-1:0] keep);
        logic [BLEN_W-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + BLEN_W'(keep[i]);
        end
        return n;
    endfunction

    logic              accept;
    logic [WPTR_W-1:0] wptr;
    logic              full;
    logic [BLEN_W-1:0] byte_cnt;
    logic              done_q;
    logic              ovs_q;
    logic [BLEN_W-1:0] blen_q;
    logic [MTU_W-1:0]  pkt_buf;
    logic [MTU_W-1:0]  pkt_buf_nxt;
    logic [MTU_W-1:0]  data_q;

    assign accept = beat.tvalid & beat.tready;

    // beats past the last slot are dropped
    always_comb begin
        pkt_buf_nxt = pkt_buf;
        if (accept && !full) begin
            pkt_buf_nxt[wptr*WORD_W +: WORD_W] = beat.tdata;
        end
    end

    always_ff @(posedge axis_in) begin
        pkt_buf <= pkt_buf_nxt;
        if (accept && beat.tlast) begin
            data_q <= pkt_buf_nxt;
        end
    end

    always_ff @(posedge axis_in or negedge rst_n) begin
        if (!rst_n) begin
            wptr     <= '0;
            full     <= 1'b0;
            byte_cnt <= '0;
            done_q   <= 1'b0;
            ovs_q    <= 1'b0;
            blen_q   <= '0;
        end else begin
            done_q <= accept & beat.tlast;
            if (accept) begin
                if (beat.tlast) begin
                    ovs_q    <= full;
                    // a dropped tlast beat adds nothing to the length
                    blen_q   <= full ? byte_cnt : byte_cnt + keep_bytes(beat.tkeep);
                    wptr     <= '0;
                    full     <= 1'b0;
                    byte_cnt <= '0;
                end else if (!full) begin
                    byte_cnt <= byte_cnt + BLEN_W'(DATA_BYTES);
                    if (wptr == LAST_SLOT) begin
                        // more beats follow a filled last slot, so the packet is oversize
                        full <= 1'b1;
                    end else begin
                        wptr <= wptr + 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        pkt.done     = done_q;
        pkt.oversize = ovs_q;
        pkt.blen     = blen_q;
        pkt.data     = data_q;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the packet checker testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f sim.f --top-module tb_axis_pkt_chk -o vsim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/vsim > sim.log 2>&1
cat sim.log

grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+common
common/pkt_chk_pkg.sv
pkt_assembler/pkt_assembler.sv
expect_table/expect_table.sv
design/pkt_matcher.sv
design/axis_pkt_chk.sv
testbench/tb_axis_pkt_chk.sv

// File: testbench/tb_axis_pkt_chk.sv
// packet checker testbench

`timescale 1ns/1ps
`default_nettype none

`include "pkt_chk_consts.svh"

module tb_axis_pkt_chk;

    localparam int NUM_PKTS   = `PKT_CHK_NUM_PKTS;
    localparam int DATA_BYTES = `PKT_CHK_DATA_BYTES;
    localparam int MTU_BYTES  = `PKT_CHK_MTU_BYTES;
    localparam int MAX_BYTES  = MTU_BYTES + DATA_BYTES;
    localparam int BLEN_W     = `PKT_CHK_BLEN_W;
    localparam int IDX_W      = `PKT_CHK_IDX_W;
    localparam int WPTR_W     = `PKT_CHK_WPTR_W;
    localparam int LATENCY    = 2;
    localparam int TIMEOUT    = 50;

    logic                       axis_in;
    logic                       rst_n;
    pkt_chk_pkg::axis_beat_t    beat;
    pkt_chk_pkg::tbl_wr_t       tbl_wr;
    pkt_chk_pkg::chk_result_t   result;
    logic [NUM_PKTS-1:0]        rcvd;
    logic [15:0]                miss_count;

    // reference model of the table and counters
    logic [7:0]                 tbl_bytes [0:NUM_PKTS-1][0:MTU_BYTES-1];
    int                         tbl_len [0:NUM_PKTS-1];
    logic [NUM_PKTS-1:0]        exp_rcvd;
    logic [15:0]                exp_miss;
    logic [7:0]                 tx_bytes [0:MAX_BYTES-1];
    int                         tx_len;
    logic [15:0]                lfsr_q;

    axis_pkt_chk u_axis_pkt_chk (
        .axis_in    (axis_in),
        .rst_n      (rst_n),
        .beat       (beat),
        .tbl_wr     (tbl_wr),
        .result     (result),
        .rcvd       (rcvd),
        .miss_count (miss_count)
    );

    always #2 axis_in = ~axis_in;

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input string name, input pkt_chk_pkg::chk_result_t got,
                                input pkt_chk_pkg::chk_result_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_rcvd(input logic [NUM_PKTS-1:0] got, input logic [NUM_PKTS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch rcvd got %h expected %h", got, exp));
        end
    endtask

    task automatic check_miss_count(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch miss_count got %h expected %h", got, exp));
        end
    endtask

    task automatic make_packet(input int len);
        logic [31:0] r;
        tx_len = len;
        for (int b = 0; b < len; b++) begin
            rand_bits(8, r);
            tx_bytes[b] = r[7:0];
        end
    endtask

    task automatic take_entry(input int idx);
        tx_len = tbl_len[idx];
        for (int b = 0; b < tx_len; b++) begin
            tx_bytes[b] = tbl_bytes[idx][b];
        end
    endtask

    // loads the current packet into one entry word by word
    task automatic load_entry(input int idx);
        logic [DATA_BYTES*8-1:0] w;
        tbl_len[idx] = tx_len;
        for (int k = 0; k * DATA_BYTES < tx_len; k++) begin
            for (int j = 0; j < DATA_BYTES; j++) begin
                tbl_bytes[idx][k*DATA_BYTES+j] = (k*DATA_BYTES+j < tx_len) ?
                                                 tx_bytes[k*DATA_BYTES+j] : 8'h00;
                w[j*8 +: 8] = tbl_bytes[idx][k*DATA_BYTES+j];
            end
            @(posedge axis_in);
            #0.5;
            tbl_wr          = '0;
            tbl_wr.wr       = 1'b1;
            tbl_wr.idx      = IDX_W'(idx);
            tbl_wr.word_idx = WPTR_W'(k);
            tbl_wr.word     = w;
            tbl_wr.set_blen = (k == 0);
            tbl_wr.blen     = BLEN_W'(tx_len);
        end
        @(posedge axis_in);
        #0.5;
        tbl_wr = '0;
    endtask

    task automatic clear_table();
        @(posedge axis_in);
        #0.5;
        tbl_wr.clear = 1'b1;
        @(posedge axis_in);
        #0.5;
        tbl_wr   = '0;
        exp_rcvd = '0;
        check_rcvd(rcvd, exp_rcvd);
    endtask

    function automatic bit entry_equal(input int i);
        if (tbl_len[i] != tx_len) begin
            return 1'b0;
        end
        for (int b = 0; b < tx_len; b++) begin
            if (tbl_bytes[i][b] !== tx_bytes[b]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // priority is oversize over new match over dup over miss
    task automatic predict(output pkt_chk_pkg::chk_result_t exp);
        int fresh;
        int seen;
        exp       = '0;
        exp.valid = 1'b1;
        fresh     = -1;
        seen      = -1;
        if (tx_len > MTU_BYTES) begin
            exp.kind = pkt_chk_pkg::CHK_OVERSIZE;
            // the buffer keeps only the first MTU bytes
            exp.blen = BLEN_W'(MTU_BYTES);
        end else begin
            exp.blen = BLEN_W'(tx_len);
            for (int i = NUM_PKTS - 1; i >= 0; i--) begin
                if (entry_equal(i) && !exp_rcvd[i]) fresh = i;
                if (entry_equal(i) && exp_rcvd[i]) seen = i;
            end
            if (fresh >= 0) begin
                exp.kind         = pkt_chk_pkg::CHK_MATCH;
                exp.idx          = IDX_W'(fresh);
                exp_rcvd[fresh]  = 1'b1;
            end else if (seen >= 0) begin
                exp.kind = pkt_chk_pkg::CHK_DUP;
                exp.idx  = IDX_W'(seen);
            end else begin
                exp.kind = pkt_chk_pkg::CHK_MISS;
            end
        end
        if (exp.kind inside {pkt_chk_pkg::CHK_MISS, pkt_chk_pkg::CHK_OVERSIZE} &&
            exp_miss != 16'hffff) begin
            exp_miss = exp_miss + 16'd1;
        end
    endtask

    // sends tx_bytes as beats with optional idle and tready-low cycles
    task automatic send_and_check(input bit gaps);
        pkt_chk_pkg::chk_result_t exp;
        pkt_chk_pkg::axis_beat_t  b;
        logic [31:0]              r;
        int                       cycles;
        bit                       seen;
        predict(exp);
        for (int k = 0; k * DATA_BYTES < tx_len; k++) begin
            b        = '0;
            b.tvalid = 1'b1;
            b.tready = 1'b1;
            b.tlast  = ((k + 1) * DATA_BYTES >= tx_len);
            for (int j = 0; j < DATA_BYTES; j++) begin
                if (k*DATA_BYTES+j < tx_len) begin
                    b.tdata[j*8 +: 8] = tx_bytes[k*DATA_BYTES+j];
                    b.tkeep[j]        = 1'b1;
                end
            end
            if (gaps) begin
                rand_bits(2, r);
                if (r[1:0] != 2'd0) begin
                    @(posedge axis_in);
                    #0.5;
                    beat        = (r[1:0] == 2'd1) ? '0 : b;
                    beat.tready = 1'b0;
                end
            end
            @(posedge axis_in);
            #0.5;
            beat = b;
        end
        // edge that accepts the tlast beat
        @(posedge axis_in);
        #0.5;
        beat   = '0;
        #0.5;
        cycles = 1;
        seen   = result.valid;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge axis_in);
            #1;
            cycles++;
            seen = result.valid;
        end
        if (!seen) report_failure("timed out waiting for result.valid after the tlast beat");
        if (cycles != LATENCY) begin
            report_failure($sformatf("result came %0d cycles after tlast instead of %0d",
                                     cycles, LATENCY));
        end
        check_result("result", result, exp);
        @(posedge axis_in);
        #1;
        check_rcvd(rcvd, exp_rcvd);
        check_miss_count(miss_count, exp_miss);
    endtask

    task automatic test_match_each();
        make_packet(64);
        load_entry(0);
        make_packet(24);
        load_entry(1);
        // ends in a partial beat
        make_packet(13);
        load_entry(2);
        make_packet(40);
        load_entry(3);
        for (int i = 0; i < 3; i++) begin
            take_entry(i);
            send_and_check(1'b0);
        end
    endtask

    task automatic test_duplicate();
        take_entry(1);
        send_and_check(1'b0);
    endtask

    task automatic test_miss();
        take_entry(2);
        tx_bytes[5] = ~tx_bytes[5];
        send_and_check(1'b0);
        make_packet(30);
        send_and_check(1'b0);
    endtask

    task automatic test_oversize();
        make_packet(MAX_BYTES);
        send_and_check(1'b0);
        take_entry(3);
        send_and_check(1'b0);
    endtask

    task automatic test_gaps();
        clear_table();
        take_entry(0);
        send_and_check(1'b0);
        clear_table();
        take_entry(0);
        send_and_check(1'b1);
    endtask

    task automatic test_clear();
        clear_table();
        take_entry(2);
        send_and_check(1'b0);
        // entry 3 becomes a copy of entry 1
        take_entry(1);
        load_entry(3);
        for (int n = 0; n < 3; n++) begin
            send_and_check(1'b1);
        end
    endtask

    initial begin
        axis_in  = 1'b0;
        rst_n    = 1'b0;
        beat     = '0;
        tbl_wr   = '0;
        lfsr_q   = 16'd39285;
        exp_rcvd = '0;
        exp_miss = '0;
        repeat (16) @(posedge axis_in);
        #0.5;
        rst_n = 1'b1;
        check_rcvd(rcvd, exp_rcvd);
        check_miss_count(miss_count, exp_miss);
        test_match_each();
        test_duplicate();
        test_miss();
        test_oversize();
        test_gaps();
        test_clear();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
